//--- src/raycast_pkg.sv
package raycast_pkg;

    // field widths shared by the whole renderer
    localparam int COL_W   = 9;   // up to 512 columns
    localparam int ROW_W   = 8;   // up to 256 rows
    localparam int TEX_W   = 5;   // 32x32 procedural texture space
    localparam int ADDR_W  = 16;  // frame buffer word address
    localparam int COLOR_W = 16;  // RGB565

    localparam logic [COLOR_W-1:0] BACKGROUND_COLOR = 16'hFFFF;
    localparam logic [COLOR_W-1:0] BLACK_WALL       = 16'h0000;
    localparam logic [COLOR_W-1:0] BRICK_RED        = 16'hF800;
    localparam logic [COLOR_W-1:0] MORTAR_GRAY      = 16'h8410;
    localparam logic [COLOR_W-1:0] CHECK_GREEN      = 16'h07E0;
    localparam logic [COLOR_W-1:0] CHECK_BLUE       = 16'h001F;
    localparam logic [COLOR_W-1:0] SHADE_MASK       = 16'h7BEF;  // drops the bit shifted across channels

    // values 6..15 are unnamed and render as background
    typedef enum logic [3:0] {
        MAP_EMPTY    = 4'd0,
        MAP_BLACK    = 4'd1,
        MAP_PATTERN  = 4'd2,
        MAP_BRICK    = 4'd3,
        MAP_CHECKER  = 4'd4,
        MAP_GRADIENT = 4'd5
    } map_type_t;

    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [7:0]       line_height;
        logic             wall_side;  // 1 = y wall
        map_type_t        map_type;
        logic [15:0]      wall_x;
    } ray_record_t;

    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] draw_start;
        logic [ROW_W-1:0] draw_end;
        logic             wall_side;
        map_type_t        map_type;
        logic [TEX_W-1:0] tex_u;
    } column_t;

    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
        logic             in_wall;
        logic [TEX_W-1:0] tex_v;
        logic             wall_side;
        map_type_t        map_type;
        logic [TEX_W-1:0] tex_u;
        logic             last;
    } row_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [COLOR_W-1:0] color;
        logic               last;
    } pixel_write_t;

endpackage

//--- src/column_decoder.sv
`timescale 1ns/1ps

module column_decoder import raycast_pkg::*; #(
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic        pixel_clk_in,
    input  logic        rst_in,
    input  logic        load,
    input  ray_record_t ray_data,
    output column_t     column
);

    localparam logic [8:0] HALF_HEIGHT = 9'(SCREEN_HEIGHT / 2);
    localparam logic [8:0] MAX_END     = 9'(SCREEN_HEIGHT);

    logic [8:0]       half;
    logic [8:0]       end_sum;
    logic [ROW_W-1:0] start_next;
    logic [ROW_W-1:0] end_next;

    // wall span around the horizon line
    always_comb begin
        half    = {2'b00, ray_data.line_height[7:1]};
        end_sum = HALF_HEIGHT + half;
        // tall walls would start above the screen
        if (half > HALF_HEIGHT) begin
            start_next = '0;
        end else begin
            start_next = ROW_W'(HALF_HEIGHT - half);
        end
        if (end_sum > MAX_END) begin
            end_next = ROW_W'(MAX_END);  // clip at the bottom row
        end else begin
            end_next = ROW_W'(end_sum);
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (load) begin
            column.col        <= ray_data.col;
            column.draw_start <= start_next;
            column.draw_end   <= end_next;
            column.wall_side  <= ray_data.wall_side;
            column.map_type   <= ray_data.map_type;
            column.tex_u      <= ray_data.wall_x[15:11];  // top bits pick the texture column
        end
    end

    // a freshly loaded column always has an ordered span
    span_ordered_a: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        load |=> (column.draw_start <= column.draw_end)
    );

endmodule

//--- src/column_walker.sv
`timescale 1ns/1ps

module column_walker import raycast_pkg::*; #(
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic     pixel_clk_in,
    input  logic     rst_in,
    input  logic     ray_valid,
    input  logic     ray_last,
    input  logic     frame_buff_ready,
    output logic     ray_ready,
    output logic     load,
    input  column_t  column,
    output logic     row_valid,
    output row_req_t row_req
);

    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(SCREEN_HEIGHT - 1);

    typedef enum logic [1:0] {
        WAIT_RAY,
        FLATTEN,
        WAIT_FRAME
    } walk_state_t;

    walk_state_t      state;
    logic [ROW_W-1:0] row_cnt;
    logic             last_col;  // current column closes the frame
    logic             final_row;
    logic             in_wall;
    logic [ROW_W-1:0] span_off;

    assign ray_ready = (state == WAIT_RAY);
    assign load      = ray_valid && ray_ready;
    assign final_row = (row_cnt == LAST_ROW);

    always_comb begin
        in_wall  = (row_cnt >= column.draw_start) && (row_cnt < column.draw_end);
        span_off = row_cnt - column.draw_start;  // only the low bits matter
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state     <= WAIT_RAY;
            row_cnt   <= '0;
            last_col  <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= (state == FLATTEN);  // one row per flatten cycle
            case (state)
                WAIT_RAY: begin
                    if (load) begin
                        last_col <= ray_last;
                        row_cnt  <= '0;
                        state    <= FLATTEN;
                    end
                end
                FLATTEN: begin
                    if (final_row) begin
                        row_cnt <= '0;
                        // end of frame waits for the frame buffer
                        if (last_col && !frame_buff_ready) begin
                            state <= WAIT_FRAME;
                        end else begin
                            state <= WAIT_RAY;
                        end
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                WAIT_FRAME: begin
                    if (frame_buff_ready) begin
                        state <= WAIT_RAY;
                    end
                end
                default: state <= WAIT_RAY;
            endcase
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (state == FLATTEN) begin
            row_req.col       <= column.col;
            row_req.row       <= row_cnt;
            row_req.in_wall   <= in_wall;
            row_req.tex_v     <= span_off[TEX_W-1:0];
            row_req.wall_side <= column.wall_side;
            row_req.map_type  <= column.map_type;
            row_req.tex_u     <= column.tex_u;
            row_req.last      <= last_col && final_row;
        end
    end

    row_in_range_a: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        row_valid |-> (row_req.row < SCREEN_HEIGHT)
    );

    // rows of one column leave back to back
    rows_contiguous_a: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        (row_valid && (row_req.row != LAST_ROW))
            |=> row_valid && (row_req.row == $past(row_req.row) + 1'b1)
    );

    // the decoded column stays put until the walker is idle again
    load_from_idle_a: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        (state != WAIT_RAY) |=> $stable(column)
    );

endmodule

//--- src/texel_shader.sv
`timescale 1ns/1ps

module texel_shader import raycast_pkg::*; #(
    parameter int SCREEN_WIDTH = 320
) (
    input  logic         pixel_clk_in,
    input  logic         rst_in,
    input  logic         row_valid,
    input  row_req_t     row_req,
    output logic         pixel_valid,
    output pixel_write_t pixel
);

    logic [ADDR_W-1:0]  addr_c;
    logic [COLOR_W-1:0] base_color;
    logic [4:0]         pattern_blue;
    logic               wall_color;  // colour came from a wall, so it may be shaded

    // stage one registers
    logic         s1_valid;
    logic         s1_shade;
    pixel_write_t s1_pix;

    assign addr_c = ADDR_W'(row_req.col) + ADDR_W'(row_req.row) * ADDR_W'(SCREEN_WIDTH);

    always_comb begin
        pattern_blue = 5'(row_req.col[8:4] + row_req.row[7:3]);
        base_color   = BACKGROUND_COLOR;
        wall_color   = 1'b0;
        if (row_req.in_wall) begin
            case (row_req.map_type)
                MAP_EMPTY: begin
                    base_color = BACKGROUND_COLOR;
                end
                MAP_BLACK: begin
                    base_color = BLACK_WALL;
                    wall_color = 1'b1;
                end
                MAP_PATTERN: begin
                    base_color = {row_req.col[8:4], row_req.row[7:2], pattern_blue};
                    wall_color = 1'b1;
                end
                MAP_BRICK: begin
                    // mortar lines every eighth texel in both directions
                    if ((row_req.tex_v[2:0] == 3'd0) || (row_req.tex_u[2:0] == 3'd0)) begin
                        base_color = MORTAR_GRAY;
                    end else begin
                        base_color = BRICK_RED;
                    end
                    wall_color = 1'b1;
                end
                MAP_CHECKER: begin
                    if (row_req.tex_u[3] != row_req.tex_v[3]) begin
                        base_color = CHECK_GREEN;
                    end else begin
                        base_color = CHECK_BLUE;
                    end
                    wall_color = 1'b1;
                end
                MAP_GRADIENT: begin
                    base_color = {row_req.tex_u, row_req.tex_v, 1'b0, 5'd0};  // red u, green v
                    wall_color = 1'b1;
                end
                default: begin
                    base_color = BACKGROUND_COLOR;  // unused map types
                end
            endcase
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            s1_valid    <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            s1_valid    <= row_valid;
            pixel_valid <= s1_valid;
        end
    end

    // stage one: address and raw colour
    always_ff @(posedge pixel_clk_in) begin
        if (row_valid) begin
            s1_pix.addr  <= addr_c;
            s1_pix.color <= base_color;
            s1_pix.last  <= row_req.last;
            s1_shade     <= wall_color && row_req.wall_side;
        end
    end

    // stage two: y walls get half brightness per channel
    always_ff @(posedge pixel_clk_in) begin
        if (s1_valid) begin
            pixel.addr <= s1_pix.addr;
            pixel.last <= s1_pix.last;
            if (s1_shade) begin
                pixel.color <= (s1_pix.color >> 1) & SHADE_MASK;
            end else begin
                pixel.color <= s1_pix.color;
            end
        end
    end

endmodule

//--- src/raycast_column_renderer.sv
`timescale 1ns/1ps

module raycast_column_renderer import raycast_pkg::*; #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic         pixel_clk_in,
    input  logic         rst_in,
    input  logic         ray_valid,
    input  ray_record_t  ray_data,
    input  logic         ray_last,
    output logic         ray_ready,
    input  logic         frame_buff_ready,
    output logic         pixel_valid,
    output pixel_write_t pixel
);

    logic     load;
    column_t  column;
    logic     row_valid;
    row_req_t row_req;

    column_decoder #(
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) decoder0 (
        .pixel_clk_in(pixel_clk_in),
        .rst_in      (rst_in),
        .load        (load),
        .ray_data    (ray_data),
        .column      (column)
    );

    // walker owns the ray handshake
    column_walker #(
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) walker0 (
        .pixel_clk_in    (pixel_clk_in),
        .rst_in          (rst_in),
        .ray_valid       (ray_valid),
        .ray_last        (ray_last),
        .frame_buff_ready(frame_buff_ready),
        .ray_ready       (ray_ready),
        .load            (load),
        .column          (column),
        .row_valid       (row_valid),
        .row_req         (row_req)
    );

    texel_shader #(
        .SCREEN_WIDTH(SCREEN_WIDTH)
    ) shader0 (
        .pixel_clk_in(pixel_clk_in),
        .rst_in      (rst_in),
        .row_valid   (row_valid),
        .row_req     (row_req),
        .pixel_valid (pixel_valid),
        .pixel       (pixel)
    );

endmodule

//--- tests/tb_color_model.svh
`ifndef TB_COLOR_MODEL_SVH
`define TB_COLOR_MODEL_SVH

// first wall row of the column
function automatic int span_start(input int line_height, input int height);
    int half;
    half = line_height / 2;
    return (half >= height / 2) ? 0 : height / 2 - half;
endfunction

// first row below the wall, clipped to the screen
function automatic int span_end(input int line_height, input int height);
    int sum;
    sum = height / 2 + line_height / 2;
    return (sum > height) ? height : sum;
endfunction

function automatic logic [15:0] expected_addr(input int col, input int row, input int width);
    return 16'(col + row * width);
endfunction

// halve red, green and blue one channel at a time
function automatic logic [15:0] halve_channels(input logic [15:0] c);
    return {1'b0, c[15:12], 1'b0, c[10:6], 1'b0, c[4:1]};
endfunction

function automatic logic [15:0] expected_color(input int col, input int row, input int start,
                                               input int stop, input logic side,
                                               input logic [3:0] mtype, input logic [4:0] tu);
    logic [4:0]  tv;
    logic [4:0]  blue;
    logic [15:0] c;
    tv   = 5'(row - start);
    blue = 5'((col >> 4) + (row >> 3));
    if (row < start || row >= stop || mtype == 4'd0 || mtype > 4'd5) begin
        return 16'hFFFF;  // background is never shaded
    end
    case (mtype)
        4'd1:    c = 16'h0000;
        4'd2:    c = {5'(col >> 4), 6'(row >> 2), blue};
        4'd3:    c = (tv[2:0] == 3'd0 || tu[2:0] == 3'd0) ? 16'h8410 : 16'hF800;
        4'd4:    c = (tu[3] != tv[3]) ? 16'h07E0 : 16'h001F;
        default: c = {tu, tv, 1'b0, 5'd0};
    endcase
    return side ? halve_channels(c) : c;
endfunction

`endif

//--- tests/raycast_tb.sv
`timescale 1ns/1ps

module raycast_tb import raycast_pkg::*; ();

    localparam int SCREEN_WIDTH   = 16;
    localparam int SCREEN_HEIGHT  = 12;
    localparam int NUM_RECORDS    = 46;  // sum over all tests below
    localparam int TIMEOUT_CYCLES = NUM_RECORDS * (SCREEN_HEIGHT + 4) + 200;

    logic         pixel_clk_in = 1'b0;
    logic         rst_in;
    logic         ray_valid;
    ray_record_t  ray_data;
    logic         ray_last;
    logic         ray_ready;
    logic         frame_buff_ready;
    logic         pixel_valid;
    pixel_write_t pixel;

    int           cyc = 0;
    int           ready_due = 0;  // cycle at which ray_ready must be back
    pixel_write_t exp_pix[$];
    int           exp_due[$];

    `include "tb_color_model.svh"

    raycast_column_renderer #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) dut0 (
        .pixel_clk_in    (pixel_clk_in),
        .rst_in          (rst_in),
        .ray_valid       (ray_valid),
        .ray_data        (ray_data),
        .ray_last        (ray_last),
        .ray_ready       (ray_ready),
        .frame_buff_ready(frame_buff_ready),
        .pixel_valid     (pixel_valid),
        .pixel           (pixel)
    );

    always #4 pixel_clk_in = ~pixel_clk_in;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge pixel_clk_in) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout, no progress after %0d cycles", cyc));
        end
    end

    task automatic compare_pixel(input pixel_write_t exp, input pixel_write_t act);
        if (exp !== act) begin
            $display("ERR t=%0t pixel exp addr=%h color=%h last=%b act addr=%h color=%h last=%b",
                     $time, exp.addr, exp.color, exp.last, act.addr, act.color, act.last);
            stop_run("pixel write mismatch");
        end
    endtask

    task automatic compare_ready(input logic exp);
        if (exp !== ray_ready) begin
            $display("ERR t=%0t ray_ready exp=%b act=%b", $time, exp, ray_ready);
            stop_run("ray_ready mismatch");
        end
    endtask

    // every write must show up exactly on its due cycle
    always @(negedge pixel_clk_in) begin
        if (rst_in) begin
        end else if (pixel_valid === 1'b1 && exp_pix.size() == 0) begin
            stop_run("pixel write with nothing expected");
        end else if (pixel_valid === 1'b1 && exp_due[0] != cyc) begin
            stop_run($sformatf("pixel write at cycle %0d, due at %0d", cyc, exp_due[0]));
        end else if (pixel_valid === 1'b1) begin
            compare_pixel(exp_pix[0], pixel);
            void'(exp_pix.pop_front());
            void'(exp_due.pop_front());
        end else if (exp_pix.size() != 0 && exp_due[0] <= cyc) begin
            stop_run($sformatf("pixel write due at cycle %0d never came", exp_due[0]));
        end
    end

    function automatic ray_record_t make_record(input int col, input int lh, input logic side,
                                                input int mtype);
        ray_record_t rec;
        rec.col         = 9'(col);
        rec.line_height = 8'(lh);
        rec.wall_side   = side;
        rec.map_type    = map_type_t'(4'(mtype));
        rec.wall_x      = 16'($urandom);
        return rec;
    endfunction

    function automatic ray_record_t random_record(input int col);
        return make_record(col, $urandom_range(0, 255), 1'($urandom), $urandom_range(0, 15));
    endfunction

    task automatic push_column(input ray_record_t rec, input logic last, input int k);
        int           start;
        int           stop;
        int           r;
        pixel_write_t p;
        start = span_start(rec.line_height, SCREEN_HEIGHT);
        stop  = span_end(rec.line_height, SCREEN_HEIGHT);
        for (r = 0; r < SCREEN_HEIGHT; r++) begin
            p.addr  = expected_addr(rec.col, r, SCREEN_WIDTH);
            p.color = expected_color(rec.col, r, start, stop, rec.wall_side,
                                     rec.map_type, rec.wall_x[15:11]);
            p.last  = last && (r == SCREEN_HEIGHT - 1);
            exp_pix.push_back(p);
            exp_due.push_back(k + 3 + r);  // two-cycle shader after the row issue
        end
    endtask

    // called at a falling edge and leaves ray_valid high
    task automatic send_record(input ray_record_t rec, input logic last);
        while (cyc < ready_due) begin
            compare_ready(1'b0);
            @(negedge pixel_clk_in);
        end
        compare_ready(1'b1);
        ray_valid = 1'b1;
        ray_data  = rec;
        ray_last  = last;
        push_column(rec, last, cyc + 1);
        ready_due = cyc + 1 + SCREEN_HEIGHT;
        @(negedge pixel_clk_in);
    endtask

    task automatic finish_burst();
        ray_valid = 1'b0;
        while (exp_pix.size() != 0) begin
            @(negedge pixel_clk_in);
        end
    endtask

    task automatic test_reset_idle();
        repeat (20) begin
            compare_ready(1'b1);
            if (pixel_valid !== 1'b0) begin
                $display("ERR t=%0t pixel_valid exp=0 act=%b", $time, pixel_valid);
                stop_run("pixel_valid not low while idle after reset");
            end
            @(negedge pixel_clk_in);
        end
    endtask

    task automatic test_map_types();
        for (int t = 0; t < 8; t++) begin
            for (int side = 0; side < 2; side++) begin
                send_record(make_record(t * 61 + side * 200, 8 + t, 1'(side), t), 1'b0);
                finish_burst();
            end
        end
    endtask

    task automatic test_line_heights();
        send_record(make_record(3, 0, 1'b0, 3), 1'b0);
        finish_burst();
        send_record(make_record(4, 255, 1'b1, 3), 1'b0);
        finish_burst();
        repeat (4) begin
            send_record(random_record($urandom_range(0, 15)), 1'b0);
            finish_burst();
        end
    endtask

    task automatic test_back_to_back();
        for (int c = 0; c < 6; c++) begin
            send_record(make_record(c, $urandom_range(0, 255), 1'($urandom), c), 1'b0);
        end
        finish_burst();
    endtask

    task automatic test_frame_end();
        frame_buff_ready = 1'b0;
        send_record(random_record(14), 1'b0);  // not the last column so no stall
        send_record(random_record(15), 1'b1);
        ray_valid = 1'b0;
        while (cyc < ready_due + 6) begin
            compare_ready(1'b0);
            @(negedge pixel_clk_in);
        end
        frame_buff_ready = 1'b1;
        @(negedge pixel_clk_in);
        compare_ready(1'b1);
        ready_due = cyc;
        finish_burst();
    endtask

    task automatic test_random_frame();
        for (int c = 0; c < 16; c++) begin
            send_record(random_record(c), 1'(c == 15));
        end
        finish_burst();
        compare_ready(1'b1);  // last column with the frame buffer ready never stalls
    endtask

    initial begin
        void'($urandom(32'h78479c15));
        rst_in           = 1'b1;
        ray_valid        = 1'b0;
        ray_data         = '0;
        ray_last         = 1'b0;
        frame_buff_ready = 1'b1;
        repeat (10) @(negedge pixel_clk_in);
        rst_in = 1'b0;
        test_reset_idle();
        test_map_types();
        test_line_heights();
        test_back_to_back();
        test_frame_end();
        test_random_frame();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- raycast_column_renderer.f
+incdir+tests
src/raycast_pkg.sv
src/column_decoder.sv
src/column_walker.sv
src/texel_shader.sv
src/raycast_column_renderer.sv
tests/raycast_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f raycast_column_renderer.f \
    --top-module raycast_tb \
    -o raycast_sim

# the simulator exits non-zero on $fatal, the grep below decides the result
sim_out=$(./obj_dir/raycast_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qxF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi
